// File: Makefile
# Verilator build and run for the gpu_core testbench
# override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= tb_gpu_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_TEXT ?= RESULT: FAIL
PASS_TEXT ?= RESULT: PASS

SIM_EXE := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_EXE) > $(LOG) 2>&1; \
	cat $(LOG); \
	if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/gpu_core_assert.sv
// bound into buffer_clear; only checks bus hold during stalls, finished pulse and reset state
`timescale 1ns/1ps

module gpu_core_assert import gpu_pkg::*; (
    input logic      CLK,
    input logic      RESET,
    input logic      master_chipselect,
    input logic      master_write,
    input bus_word_t master_address,
    input bus_word_t master_writedata,
    input logic      master_waitrequest,
    input logic      master_writeresponsevalid,
    input logic      finished
);

    logic stalled;

    // word on the bus but not completed this cycle
    assign stalled = master_write && !(master_writeresponsevalid && !master_waitrequest);

    hold_on_stall: assert property (@(posedge CLK) disable iff (RESET)
        stalled |=> master_write && $stable(master_address) && $stable(master_writedata))
        else $error("master word changed or dropped during a stall");

    finished_alone: assert property (@(posedge CLK) disable iff (RESET)
        !(finished && master_write))
        else $error("finished pulse overlaps an active master write");

    // bus quiet right after any reset cycle
    quiet_after_reset: assert property (@(posedge CLK)
        RESET |=> !master_write && !master_chipselect && !finished)
        else $error("master bus active after reset");

endmodule

bind buffer_clear gpu_core_assert u_assert (
    .CLK                       (CLK),
    .RESET                     (RESET),
    .master_chipselect         (master_chipselect),
    .master_write              (master_write),
    .master_address            (master_address),
    .master_writedata          (master_writedata),
    .master_waitrequest        (master_waitrequest),
    .master_writeresponsevalid (master_writeresponsevalid),
    .finished                  (ctrl.finished)
);

// File: bench/tb_gpu_core.sv
// 8x6 buffer, fixed seed; bases kept below 0x10000000 so the address order check never wraps
`timescale 1ns/1ps

module tb_gpu_core import gpu_pkg::*; ();

    localparam int        FB_WIDTH   = 8;
    localparam int        FB_HEIGHT  = 6;
    localparam int        NUM_WORDS  = FB_WIDTH * FB_HEIGHT;
    localparam int        NUM_RUNS   = 12;
    localparam int        POLL_LIMIT = 500;
    localparam int        STALL_PCT  = 40;   // percent of cycles with waitrequest
    localparam bit [31:0] SEED       = 32'h2a39;
    localparam bus_word_t SKY_FILL   = 32'h0087_CEEB;
    localparam bus_word_t DEPTH_FILL = 32'h7FFF_FFFF;
    localparam bus_word_t A_FRAME    = bus_word_t'(REG_FRAME_PTR);
    localparam bus_word_t A_START    = bus_word_t'(REG_START);
    localparam bus_word_t A_DONE     = bus_word_t'(REG_DONE);
    localparam bus_word_t A_ZBUF     = bus_word_t'(REG_ZBUF_PTR);
    localparam bus_word_t A_MODE     = bus_word_t'(REG_MODE);

    logic      CLK;
    logic      RESET;
    logic      slave_chipselect;
    logic      slave_read;
    logic      slave_write;
    bus_word_t slave_address;
    bus_word_t slave_writedata;
    bus_word_t slave_readdata;
    logic      master_chipselect;
    logic      master_write;
    bus_word_t master_address;
    bus_word_t master_writedata;
    logic      master_waitrequest;
    logic      master_writeresponsevalid;

    bus_word_t mem_model [bus_word_t]; // byte address -> word
    bus_word_t write_order [$];        // completed addresses in bus order
    int        write_cycles = 0;       // cycles with master_write high
    int        checks       = 0;
    int        errors       = 0;
    int        timeouts     = 0;

    gpu_core #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_dut (
        .CLK                       (CLK),
        .RESET                     (RESET),
        .slave_chipselect          (slave_chipselect),
        .slave_read                (slave_read),
        .slave_write               (slave_write),
        .slave_address             (slave_address),
        .slave_writedata           (slave_writedata),
        .slave_readdata            (slave_readdata),
        .master_chipselect         (master_chipselect),
        .master_write              (master_write),
        .master_address            (master_address),
        .master_writedata          (master_writedata),
        .master_waitrequest        (master_waitrequest),
        .master_writeresponsevalid (master_writeresponsevalid)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // memory side: random stalls, any other cycle completes the word
    initial begin
        logic stall;
        master_waitrequest        = 1'b0;
        master_writeresponsevalid = 1'b0;
        forever begin
            @(posedge CLK);
            stall = ($urandom_range(0, 99) < STALL_PCT);
            master_waitrequest        <= stall;
            master_writeresponsevalid <= !stall;
        end
    end

    task automatic compare_word(input string what, input bus_word_t got, input bus_word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED time=%0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic record_write(input bus_word_t addr, input bus_word_t data);
        checks++;
        assert (!mem_model.exists(addr)) else begin
            errors++;
            $display("CHECK FAILED time=%0t address %h written twice", $time, addr);
        end
        if (write_order.size() > 0) begin
            checks++;
            assert (addr > write_order[write_order.size() - 1]) else begin
                errors++;
                $display("CHECK FAILED time=%0t address %h out of order after %h",
                         $time, addr, write_order[write_order.size() - 1]);
            end
        end
        mem_model[addr] = data;
        write_order.push_back(addr);
    endtask

    // bus sampled mid-cycle, away from both drive edges
    always @(negedge CLK) begin
        if (!RESET && master_write) begin
            write_cycles++;
            if (master_chipselect && master_writeresponsevalid && !master_waitrequest) begin
                record_write(master_address, master_writedata);
            end
        end
    end

    task automatic write_reg(input bus_word_t addr, input bus_word_t data);
        @(posedge CLK);
        slave_chipselect <= 1'b1;
        slave_write      <= 1'b1;
        slave_address    <= addr;
        slave_writedata  <= data;
        @(posedge CLK);
        slave_chipselect <= 1'b0;
        slave_write      <= 1'b0;
    endtask

    task automatic read_reg(input bus_word_t addr, output bus_word_t data);
        @(posedge CLK);
        slave_chipselect <= 1'b1;
        slave_read       <= 1'b1;
        slave_address    <= addr;
        @(negedge CLK);
        data = slave_readdata; // combinational readback
        @(posedge CLK);
        slave_chipselect <= 1'b0;
        slave_read       <= 1'b0;
    endtask

    task automatic check_reg(input bus_word_t addr, input bus_word_t exp, input string what);
        bus_word_t value;
        read_reg(addr, value);
        compare_word(what, value, exp);
    endtask

    task automatic check_unmapped();
        int a;
        for (a = 4; a < 16; a++) begin
            if (a != 8) begin
                check_reg(bus_word_t'(a), 32'd0, $sformatf("unmapped word %0d", a));
            end
        end
        check_reg($urandom | 32'h0000_0010, 32'd0, "unmapped high word");
    endtask

    task automatic wait_for_done(output bit seen);
        bus_word_t value;
        int        polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < POLL_LIMIT) begin
            read_reg(A_DONE, value);
            seen = value[0];
            polls++;
        end
    endtask

    function automatic bus_word_t pick_mode(input int k);
        case (k)
            0:       return 32'd2;
            1:       return 32'd3;
            2:       return 32'd0;
            default: return 32'd5;
        endcase
    endfunction

    // program, start, wait for done, compare the model, then drop start and done
    task automatic run_job(input bus_word_t mode);
        bus_word_t frame_base;
        bus_word_t zbuf_base;
        bus_word_t base;
        bus_word_t fill;
        bus_word_t addr;
        bit        seen;
        int        i;
        int        words_at_done;
        frame_base = $urandom & 32'h0FFF_FFFC;
        zbuf_base  = $urandom & 32'h0FFF_FFFC;
        write_reg(A_FRAME, frame_base);
        write_reg(A_ZBUF, zbuf_base);
        write_reg(A_MODE, mode);
        check_reg(A_FRAME, frame_base, "frame pointer readback");
        check_reg(A_ZBUF, zbuf_base, "depth pointer readback");
        check_reg(A_MODE, mode, "mode readback");
        check_reg(A_DONE, 32'd0, "done before start");
        mem_model.delete();
        write_order.delete();
        write_cycles = 0;
        write_reg(A_START, 32'd1);
        wait_for_done(seen);
        if (!seen) begin
            timeouts++;
            $display("timeout: done did not rise within %0d polls for mode %0d",
                     POLL_LIMIT, mode);
        end else begin
            check_reg(A_START, 32'd1, "start readback");
            if (mode == 32'd2 || mode == 32'd3) begin
                base = (mode == 32'd2) ? frame_base : zbuf_base;
                fill = (mode == 32'd2) ? SKY_FILL : DEPTH_FILL;
                compare_word("words written", bus_word_t'(write_order.size()), NUM_WORDS);
                compare_word("addresses touched", bus_word_t'(mem_model.num()), NUM_WORDS);
                for (i = 0; i < NUM_WORDS; i++) begin
                    addr = base + bus_word_t'(i) * 32'd4;
                    compare_word($sformatf("word %0d present at %h", i, addr),
                                 bus_word_t'(mem_model.exists(addr)), 32'd1);
                    if (mem_model.exists(addr)) begin
                        compare_word($sformatf("fill of word %0d", i), mem_model[addr], fill);
                    end
                end
            end else begin
                compare_word("write cycles for unsupported mode",
                             bus_word_t'(write_cycles), 32'd0);
            end
            words_at_done = write_order.size();
            write_reg(A_START, 32'd0);
            repeat (3) @(posedge CLK);
            check_reg(A_DONE, 32'd1, "done held after start dropped");
            write_reg(A_DONE, 32'd0);
            check_reg(A_DONE, 32'd0, "done cleared by software");
            compare_word("writes after done", bus_word_t'(write_order.size()),
                         bus_word_t'(words_at_done));
        end
    endtask

    initial begin
        int        run;
        bus_word_t mode;
        void'($urandom(SEED));
        RESET            = 1'b1;
        slave_chipselect = 1'b0;
        slave_read       = 1'b0;
        slave_write      = 1'b0;
        slave_address    = '0;
        slave_writedata  = '0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        check_unmapped();
        // first four runs cover every mode once
        for (run = 0; run < NUM_RUNS && timeouts == 0; run++) begin
            mode = (run < 4) ? pick_mode(run) : pick_mode($urandom_range(0, 3));
            run_job(mode);
        end
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: source/buffer_clear.sv
// writes FB_WIDTH*FB_HEIGHT words from base; a word completes on response valid without wait
`timescale 1ns/1ps

module buffer_clear import gpu_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  logic         CLK,
    input  logic         RESET,
    input  logic         master_waitrequest,
    input  logic         master_writeresponsevalid,
    output logic         master_chipselect,
    output logic         master_write,
    output bus_word_t    master_address,
    output bus_word_t    master_writedata,
    clear_ctrl_if.engine ctrl
);

    localparam int NUM_WORDS = FB_WIDTH * FB_HEIGHT;
    localparam int IDX_W     = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);

    logic             busy;
    logic [IDX_W-1:0] idx;    // current word
    bus_word_t        base_q;
    bus_word_t        fill_q;
    logic             word_done;

    assign word_done = busy && master_writeresponsevalid && !master_waitrequest;

    // bus held steady for the whole word, zero when idle
    assign master_chipselect = busy;
    assign master_write      = busy;
    assign master_address    = busy ? base_q + bus_word_t'(idx) * BYTES_PER_PIXEL : '0;
    assign master_writedata  = busy ? fill_q : '0;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy          <= 1'b0;
            idx           <= '0;
            ctrl.finished <= 1'b0;
        end else begin
            ctrl.finished <= 1'b0;
            if (!busy && ctrl.go) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (word_done) begin
                if (idx == LAST_IDX) begin
                    busy          <= 1'b0;
                    ctrl.finished <= 1'b1; // lands while write is already low
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // job payload
    always_ff @(posedge CLK) begin
        if (!busy && ctrl.go) begin
            base_q <= ctrl.base;
            fill_q <= ctrl.fill;
        end
    end

endmodule

// File: source/clear_ctrl_if.sv
// fill job handoff; go is a one-cycle pulse, only legal while the engine is idle
`timescale 1ns/1ps

interface clear_ctrl_if import gpu_pkg::*; ();

    logic      go;       // start a fill, one cycle
    bus_word_t base;     // byte address of word 0
    bus_word_t fill;     // word written everywhere
    logic      finished; // one cycle after the last word completes

    // sequencer side
    modport seq (
        output go,
        output base,
        output fill,
        input  finished
    );

    // clear engine side
    modport engine (
        input  go,
        input  base,
        input  fill,
        output finished
    );

endinterface

// File: source/gpu_core.sv
// clear-only graphics core; slave address is a word index, master address a byte address
`timescale 1ns/1ps

module gpu_core import gpu_pkg::*; #(
    parameter int FB_WIDTH  = 320,
    parameter int FB_HEIGHT = 240
) (
    input  logic      CLK,
    input  logic      RESET,
    // register slave
    input  logic      slave_chipselect,
    input  logic      slave_read,
    input  logic      slave_write,
    input  bus_word_t slave_address,
    input  bus_word_t slave_writedata,
    output bus_word_t slave_readdata,
    // memory master, write only
    output logic      master_chipselect,
    output logic      master_write,
    output bus_word_t master_address,
    output bus_word_t master_writedata,
    input  logic      master_waitrequest,
    input  logic      master_writeresponsevalid
);

    logic      start;
    logic      set_done;
    bus_word_t mode;
    bus_word_t frame_ptr;
    bus_word_t zbuf_ptr;

    clear_ctrl_if clear_ctrl ();

    gpu_regs u_regs (
        .CLK              (CLK),
        .RESET            (RESET),
        .slave_chipselect (slave_chipselect),
        .slave_read       (slave_read),
        .slave_write      (slave_write),
        .slave_address    (slave_address),
        .slave_writedata  (slave_writedata),
        .slave_readdata   (slave_readdata),
        .set_done         (set_done),
        .start            (start),
        .mode             (mode),
        .frame_ptr        (frame_ptr),
        .zbuf_ptr         (zbuf_ptr)
    );

    gpu_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .start     (start),
        .mode      (mode),
        .frame_ptr (frame_ptr),
        .zbuf_ptr  (zbuf_ptr),
        .set_done  (set_done),
        .ctrl      (clear_ctrl.seq)
    );

    buffer_clear #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_clear (
        .CLK                       (CLK),
        .RESET                     (RESET),
        .master_waitrequest        (master_waitrequest),
        .master_writeresponsevalid (master_writeresponsevalid),
        .master_chipselect         (master_chipselect),
        .master_write              (master_write),
        .master_address            (master_address),
        .master_writedata          (master_writedata),
        .ctrl                      (clear_ctrl.engine)
    );

endmodule

// File: source/gpu_pkg.sv
// shared by all core modules; register addresses are word indexes, pointers are byte addresses
package gpu_pkg;

    // one bus word, data and addresses alike
    typedef logic [31:0] bus_word_t;

    // slave register map, word addresses
    localparam logic [3:0] REG_FRAME_PTR = 4'd0;
    localparam logic [3:0] REG_START     = 4'd1;
    localparam logic [3:0] REG_DONE      = 4'd2;
    localparam logic [3:0] REG_ZBUF_PTR  = 4'd3;
    localparam logic [3:0] REG_MODE      = 4'd8; // 4..7 were cube registers

    // mode codes understood by the sequencer
    localparam bus_word_t MODE_CLEAR_FRAME = 32'd2;
    localparam bus_word_t MODE_CLEAR_DEPTH = 32'd3;

    // fill words
    localparam bus_word_t SKY_COLOR = 32'h0087_CEEB; // 0x00RRGGBB
    localparam bus_word_t FAR_DEPTH = 32'h7FFF_FFFF; // largest positive depth

    // address step between pixels
    localparam bus_word_t BYTES_PER_PIXEL = 32'd4;

    // sequencer control states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RUNNING = 2'd1,
        DONE    = 2'd2
    } seq_state_t;

endpackage

// File: source/gpu_regs.sv
// zero wait state slave; readdata is combinational and only start/done bit 0 is stored
`timescale 1ns/1ps

module gpu_regs import gpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      slave_chipselect,
    input  logic      slave_read,
    input  logic      slave_write,
    input  bus_word_t slave_address,
    input  bus_word_t slave_writedata,
    output bus_word_t slave_readdata,
    input  logic      set_done,
    output logic      start,
    output bus_word_t mode,
    output bus_word_t frame_ptr,
    output bus_word_t zbuf_ptr
);

    logic done;
    logic rd_en;
    logic wr_en;

    assign rd_en = slave_chipselect && slave_read;
    assign wr_en = slave_chipselect && slave_write;

    // read mux, unmapped words return zero
    always_comb begin
        slave_readdata = '0;
        if (rd_en) begin
            case (slave_address)
                bus_word_t'(REG_FRAME_PTR): slave_readdata = frame_ptr;
                bus_word_t'(REG_START):     slave_readdata = {31'd0, start};
                bus_word_t'(REG_DONE):      slave_readdata = {31'd0, done};
                bus_word_t'(REG_ZBUF_PTR):  slave_readdata = zbuf_ptr;
                bus_word_t'(REG_MODE):      slave_readdata = mode;
                default:                    slave_readdata = '0;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_ptr <= '0;
            zbuf_ptr  <= '0;
            mode      <= '0;
            start     <= 1'b0;
            done      <= 1'b0;
        end else begin
            if (wr_en) begin
                case (slave_address)
                    bus_word_t'(REG_FRAME_PTR): frame_ptr <= slave_writedata;
                    bus_word_t'(REG_START):     start     <= slave_writedata[0];
                    bus_word_t'(REG_DONE):      done      <= slave_writedata[0];
                    bus_word_t'(REG_ZBUF_PTR):  zbuf_ptr  <= slave_writedata;
                    bus_word_t'(REG_MODE):      mode      <= slave_writedata;
                    default: ;                  // ignored
                endcase
            end
            // hardware completion wins over a software write in the same cycle
            if (set_done) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: source/gpu_sequencer.sv
// go and set_done are combinational pulses; mode is sampled only when leaving IDLE
`timescale 1ns/1ps

module gpu_sequencer import gpu_pkg::*; (
    input  logic      CLK,
    input  logic      RESET,
    input  logic      start,
    input  bus_word_t mode,
    input  bus_word_t frame_ptr,
    input  bus_word_t zbuf_ptr,
    output logic      set_done,
    clear_ctrl_if.seq ctrl
);

    seq_state_t state;
    seq_state_t state_next;
    logic       is_clear;

    assign is_clear = (mode == MODE_CLEAR_FRAME) || (mode == MODE_CLEAR_DEPTH);

    // job description, latched by the engine on go
    assign ctrl.base = (mode == MODE_CLEAR_DEPTH) ? zbuf_ptr  : frame_ptr;
    assign ctrl.fill = (mode == MODE_CLEAR_DEPTH) ? FAR_DEPTH : SKY_COLOR;

    always_comb begin
        state_next = state;
        ctrl.go    = 1'b0;
        set_done   = 1'b0;
        case (state)
            IDLE: begin
                if (start) begin
                    if (is_clear) begin
                        ctrl.go    = 1'b1;
                        state_next = RUNNING;
                    end else begin
                        set_done   = 1'b1; // nothing to do for other modes
                        state_next = DONE;
                    end
                end
            end
            RUNNING: begin
                if (ctrl.finished) begin
                    set_done   = 1'b1;
                    state_next = DONE;
                end
            end
            DONE: begin
                if (!start) begin // wait for software to drop start
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: verilog.f
source/gpu_pkg.sv
source/clear_ctrl_if.sv
source/gpu_regs.sv
source/gpu_sequencer.sv
source/buffer_clear.sv
source/gpu_core.sv
bench/gpu_core_assert.sv
bench/tb_gpu_core.sv
